/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert
TOP       = snd_tb
FILELIST  = vlog.f
LOG       = sim.log
FAIL_MSG  = === FAIL ===
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* source/snd_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface snd_bus_if;
    import snd_pkg::*;

    addr_t addr;
    logic  rnw;     // high for reads
    data_t wdata;
    logic  cen;     // write qualifier, cpu clock enable

    // the decoder drives the bus
    modport host (output addr, rnw, wdata, cen);

    // tone chips and pcm player only listen
    modport dev (input addr, rnw, wdata, cen);

endinterface

`default_nettype wire

/* source/snd_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module snd_decoder #(
    parameter int BANKS = 0
)(
    input  logic           clk,
    input  logic           rst,
    input  logic           cen_opn,
    input  snd_pkg::addr_t cpu_addr,
    input  logic           cpu_rnw,
    input  snd_pkg::data_t cpu_dout,
    input  logic           snreq,
    input  snd_pkg::data_t latch,
    input  snd_pkg::data_t rom_data,
    input  logic           rom_ok,
    input  snd_pkg::data_t ram_q,
    input  snd_pkg::data_t opn_q,
    input  snd_pkg::data_t opl_q,
    input  snd_pkg::data_t pcm_q,
    snd_bus_if.host        bus,
    output snd_pkg::data_t cpu_din,
    output logic           rdy,
    output logic           nmin,
    output logic           rom_cs,
    output logic           snd_bank,
    output logic           ram_we,
    output logic           opn_cs,
    output logic           opl_cs,
    output logic           pcm_cs
);
    import snd_pkg::*;

    logic  ram_cs, nmi_clr, bank_cs;
    logic  dev_cs;      // registered, a device was selected
    logic  snreq_l;
    data_t dev_mux;

    assign bus.addr  = cpu_addr;
    assign bus.rnw   = cpu_rnw;
    assign bus.wdata = cpu_dout;
    assign bus.cen   = cen_opn;

    assign ram_we  = ram_cs & ~cpu_rnw;
    assign rdy     = ~rom_cs | rom_ok;     // hold the cpu during rom fetch
    assign bank_cs = (BANKS != 0) && cpu_addr[15] && !cpu_rnw;

    always_comb begin
        ram_cs  = 1'b0;
        opn_cs  = 1'b0;
        opl_cs  = 1'b0;
        pcm_cs  = 1'b0;
        nmi_clr = 1'b0;
        rom_cs  = |cpu_addr[15:14];
        if (cpu_addr[15:14] == 2'd0) begin
            case (cpu_addr[13:11])
                3'd0:    ram_cs  = 1'b1;
                3'd1:    opn_cs  = 1'b1;
                3'd2:    opl_cs  = 1'b1;
                3'd6:    nmi_clr = cpu_rnw;  // latch read acks the nmi
                3'd7:    pcm_cs  = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        dev_mux <= opn_cs ? opn_q : opl_cs ? opl_q : pcm_q;
        if (rst) dev_cs <= 1'b0;
        else     dev_cs <= opn_cs | opl_cs | pcm_cs;
    end

    assign cpu_din = rom_cs  ? rom_data :
                     ram_cs  ? ram_q    :
                     nmi_clr ? latch    :
                     dev_cs  ? dev_mux  : 8'hff;

    // command latch interrupt, only the rising edge of snreq counts
    always_ff @(posedge clk) begin
        if (rst) begin
            nmin     <= 1'b1;
            snreq_l  <= 1'b0;
            snd_bank <= 1'b0;
        end else begin
            snreq_l <= snreq;
            if (nmi_clr)               nmin <= 1'b1;
            else if (snreq && !snreq_l) nmin <= 1'b0;
            if (bank_cs) snd_bank <= cpu_dout[0];
        end
    end

endmodule

`default_nettype wire

/* source/snd_mixer.sv */
`timescale 1ns/1ns
`default_nettype none

module snd_mixer(
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic             enable_psg,
    input  logic             enable_fm,
    input  logic [1:0]       fxlevel,
    input  snd_pkg::voice_t  opn_voice,
    input  snd_pkg::voice_t  opl_voice,
    input  snd_pkg::pcm_t    pcm,
    output snd_pkg::sample_t snd,
    output logic             peak
);
    import snd_pkg::*;

    // two guard bits over the 16-bit output
    localparam logic signed [17:0] sat_hi = 18'sd32767;
    localparam logic signed [17:0] sat_lo = -18'sd32768;

    logic signed [17:0] opn_part, opl_part, pcm_part, sum;

    assign opn_part = enable_psg ? 18'(opn_voice) : '0;
    assign opl_part = enable_fm  ? 18'(opl_voice) : '0;
    assign pcm_part = 18'(pcm) <<< (fxlevel + 3'd4);   // x16 then fx gain
    assign sum      = opn_part + opl_part + pcm_part;

    always_ff @(posedge clk) begin
        if (rst) begin
            snd  <= '0;
            peak <= 1'b0;
        end else if (cen) begin
            if (sum > sat_hi) begin
                snd  <= 16'sh7fff;
                peak <= 1'b1;
            end else if (sum < sat_lo) begin
                snd  <= 16'sh8000;
                peak <= 1'b1;
            end else begin
                snd  <= sample_t'(sum[15:0]);
                peak <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/snd_pcm_player.sv */
`timescale 1ns/1ns
`default_nettype none

module snd_pcm_player(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    snd_bus_if.dev               bus,
    input  logic                 cs,
    input  snd_pkg::data_t       adpcm_data,
    input  logic                 adpcm_ok,
    output snd_pkg::data_t       dout,
    output snd_pkg::adpcm_addr_t adpcm_addr,
    output logic                 adpcm_cs,
    output snd_pkg::pcm_t        pcm
);
    import snd_pkg::*;

    typedef enum logic [1:0] {
        idle,
        fetch,   // waiting for the sample rom
        hold     // byte out, wait for the next tick
    } state_t;

    state_t state;
    data_t  start_hi;
    logic   wr, busy;

    assign wr       = bus.cen & cs & ~bus.rnw;
    assign busy     = state != idle;
    assign adpcm_cs = state == fetch;
    assign dout     = {7'd0, busy};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            start_hi   <= '0;
            adpcm_addr <= '0;
            pcm        <= '0;
        end else begin
            case (state)
                fetch: begin
                    if (adpcm_ok) begin
                        if (adpcm_data == PCM_END) begin
                            pcm   <= '0;       // silence after the marker
                            state <= idle;
                        end else begin
                            pcm        <= pcm_t'(adpcm_data);
                            adpcm_addr <= adpcm_addr + 1'd1;
                            state      <= hold;
                        end
                    end
                end
                hold: if (cen) state <= fetch;
                default: ;
            endcase
            // register writes, a start restarts any running sample
            if (wr) begin
                if (!bus.addr[0]) begin
                    start_hi <= bus.wdata;
                end else begin
                    adpcm_addr <= {start_hi, bus.wdata, 2'b00};
                    state      <= fetch;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/snd_pkg.sv */
`default_nettype none

package snd_pkg;

    // sound cpu bus
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // sample rom side
    typedef logic [17:0]        adpcm_addr_t;
    typedef logic signed [7:0]  pcm_t;

    // audio paths
    typedef logic signed [15:0] voice_t;   // one tone chip
    typedef logic signed [15:0] sample_t;  // mixed stream

    // tone chip registers, addr[1:0]
    localparam logic [1:0] TONE_PERIOD = 2'd0;
    localparam logic [1:0] TONE_AMP    = 2'd1;
    localparam logic [1:0] TONE_TIMER  = 2'd2;
    localparam logic [1:0] TONE_CTRL   = 2'd3;

    // stop marker in sample rom
    localparam data_t PCM_END = 8'h80;

endpackage

`default_nettype wire

/* source/snd_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module snd_ram #(
    parameter int aw = 11
)(
    input  logic           clk,
    input  logic           we,
    input  logic [aw-1:0]  addr,
    input  snd_pkg::data_t data,
    output snd_pkg::data_t q
);
    import snd_pkg::*;

    data_t mem [0:2**aw-1];

    // read during write gives the old byte
    always_ff @(posedge clk) begin
        if (we) mem[addr] <= data;
        q <= mem[addr];
    end

endmodule

`default_nettype wire

/* source/snd_tone_chip.sv */
`timescale 1ns/1ns
`default_nettype none

module snd_tone_chip(
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    snd_bus_if.dev          bus,
    input  logic            cs,
    output snd_pkg::data_t  dout,
    output logic            irqn,
    output snd_pkg::voice_t voice
);
    import snd_pkg::*;

    data_t       period, sq_cnt;
    data_t       reload, tmr_cnt;
    logic [10:0] amp;      // bits 10:8 set through ctrl[6:4]
    logic        sq, tmr_en, flag, wr;
    voice_t      level;

    assign wr    = bus.cen & cs & ~bus.rnw;
    assign level = {1'b0, amp, 4'd0};     // amp times 16
    assign voice = sq ? level : -level;
    assign irqn  = ~flag;
    assign dout  = {flag, 6'd0, tmr_en};

    always_ff @(posedge clk) begin
        if (rst) begin
            period  <= '0;
            sq_cnt  <= '0;
            reload  <= '0;
            tmr_cnt <= '0;
            amp     <= '0;
            sq      <= 1'b0;
            tmr_en  <= 1'b0;
            flag    <= 1'b0;
        end else begin
            if (cen) begin
                // square wave, half period is period+1 ticks
                if (sq_cnt == period) begin
                    sq_cnt <= '0;
                    sq     <= ~sq;
                end else begin
                    sq_cnt <= sq_cnt + 1'd1;
                end
                if (tmr_en) begin
                    if (tmr_cnt == '0) begin
                        flag    <= 1'b1;
                        tmr_cnt <= reload;
                    end else begin
                        tmr_cnt <= tmr_cnt - 1'd1;
                    end
                end
            end
            if (wr) begin
                case (bus.addr[1:0])
                    TONE_PERIOD: period   <= bus.wdata;
                    TONE_AMP:    amp[7:0] <= bus.wdata;
                    TONE_TIMER: begin
                        reload  <= bus.wdata;
                        tmr_cnt <= bus.wdata;
                    end
                    TONE_CTRL: begin
                        tmr_en    <= bus.wdata[0];
                        amp[10:8] <= bus.wdata[6:4];
                        if (bus.wdata[1]) flag <= 1'b0;   // clear wins over a new tick
                        if (bus.wdata[0] && !tmr_en) tmr_cnt <= reload;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/snd_top.sv */
`timescale 1ns/1ns
`default_nettype none

module snd_top #(
    parameter int BANKS = 0,
    parameter int aw    = 11
)(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen_opn,
    input  logic                 cen_opl,
    input  logic                 enable_psg,
    input  logic                 enable_fm,
    input  logic [1:0]           fxlevel,
    input  logic                 snreq,
    input  snd_pkg::data_t       latch,
    input  snd_pkg::addr_t       cpu_addr,
    input  logic                 cpu_rnw,
    input  snd_pkg::data_t       cpu_dout,
    input  snd_pkg::data_t       rom_data,
    input  logic                 rom_ok,
    input  snd_pkg::data_t       adpcm_data,
    input  logic                 adpcm_ok,
    output snd_pkg::data_t       cpu_din,
    output logic                 rdy,
    output logic                 irqn,
    output logic                 nmin,
    output snd_pkg::addr_t       rom_addr,
    output logic                 rom_cs,
    output logic                 snd_bank,
    output snd_pkg::adpcm_addr_t adpcm_addr,
    output logic                 adpcm_cs,
    output snd_pkg::sample_t     snd,
    output logic                 sample,
    output logic                 peak
);
    import snd_pkg::*;

    snd_bus_if bus();

    data_t  ram_q, opn_q, opl_q, pcm_q;
    logic   ram_we, opn_cs, opl_cs, pcm_cs;
    logic   opn_irqn, opl_irqn;
    voice_t opn_voice, opl_voice;
    pcm_t   pcm;

    assign irqn     = opn_irqn & opl_irqn;   // wired interrupt
    assign rom_addr = cpu_addr;
    assign sample   = cen_opn;

    snd_decoder #(.BANKS(BANKS)) u_decoder(
        .clk(clk), .rst(rst), .cen_opn(cen_opn),
        .cpu_addr(cpu_addr), .cpu_rnw(cpu_rnw), .cpu_dout(cpu_dout),
        .snreq(snreq), .latch(latch), .rom_data(rom_data), .rom_ok(rom_ok),
        .ram_q(ram_q), .opn_q(opn_q), .opl_q(opl_q), .pcm_q(pcm_q),
        .bus(bus), .cpu_din(cpu_din), .rdy(rdy), .nmin(nmin),
        .rom_cs(rom_cs), .snd_bank(snd_bank), .ram_we(ram_we),
        .opn_cs(opn_cs), .opl_cs(opl_cs), .pcm_cs(pcm_cs)
    );

    snd_ram #(.aw(aw)) u_ram(
        .clk(clk), .we(ram_we), .addr(cpu_addr[aw-1:0]), .data(cpu_dout), .q(ram_q)
    );

    snd_tone_chip u_opn(
        .clk(clk), .rst(rst), .cen(cen_opn), .bus(bus), .cs(opn_cs),
        .dout(opn_q), .irqn(opn_irqn), .voice(opn_voice)
    );

    snd_tone_chip u_opl(
        .clk(clk), .rst(rst), .cen(cen_opl), .bus(bus), .cs(opl_cs),
        .dout(opl_q), .irqn(opl_irqn), .voice(opl_voice)
    );

    snd_pcm_player u_pcm(
        .clk(clk), .rst(rst), .cen(cen_opl), .bus(bus), .cs(pcm_cs),
        .adpcm_data(adpcm_data), .adpcm_ok(adpcm_ok), .dout(pcm_q),
        .adpcm_addr(adpcm_addr), .adpcm_cs(adpcm_cs), .pcm(pcm)
    );

    snd_mixer u_mixer(
        .clk(clk), .rst(rst), .cen(cen_opn),
        .enable_psg(enable_psg), .enable_fm(enable_fm), .fxlevel(fxlevel),
        .opn_voice(opn_voice), .opl_voice(opl_voice), .pcm(pcm),
        .snd(snd), .peak(peak)
    );

endmodule

`default_nettype wire

/* tests/snd_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module snd_properties(
    input logic clk,
    input logic rst,
    input logic cen_opn,
    input logic rom_cs,
    input logic rdy,
    input logic adpcm_cs,
    input logic adpcm_ok,
    input logic sample
);

    rom_cs_quiet_in_reset: assert property (@(posedge clk) rst |-> !$rose(rom_cs))
        else $error("rom_cs rose during reset");

    rdy_without_rom: assert property (@(posedge clk) disable iff (rst) !rom_cs |-> rdy)
        else $error("rdy low with rom_cs low");

    // fetch is held until the sample rom answers
    adpcm_cs_held: assert property (@(posedge clk) disable iff (rst)
        (adpcm_cs && !adpcm_ok) |=> adpcm_cs)
        else $error("adpcm_cs dropped before adpcm_ok");

    sample_is_cen: assert property (@(posedge clk) sample == cen_opn)
        else $error("sample differs from cen_opn");

endmodule

bind snd_top snd_properties props_i(
    .clk(clk), .rst(rst), .cen_opn(cen_opn), .rom_cs(rom_cs), .rdy(rdy),
    .adpcm_cs(adpcm_cs), .adpcm_ok(adpcm_ok), .sample(sample)
);

`default_nettype wire

/* tests/snd_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module snd_tb;
    import snd_pkg::*;

    localparam addr_t IDLE = 16'h1800;   // unmapped address parked between cycles

    logic clk, rst, cen_opn, cen_opl, enable_psg, enable_fm, snreq, cpu_rnw;
    logic rom_ok, adpcm_ok, rdy, irqn, nmin, rom_cs, snd_bank, adpcm_cs, sample, peak;
    logic [1:0] fxlevel;
    addr_t cpu_addr, rom_addr;
    data_t latch, cpu_dout, rom_data, adpcm_data, cpu_din;
    adpcm_addr_t adpcm_addr, pcm_base;
    sample_t snd;
    int mismatches, failures, cen_cnt, rom_wait, pcm_wait, seed;
    adpcm_addr_t fetched[$];
    data_t pcm_table[0:3];

    snd_top #(.BANKS(1), .aw(11)) dut_i(.*);

    function automatic data_t rom_byte(addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    function automatic data_t pcm_byte(adpcm_addr_t a);
        adpcm_addr_t idx;
        idx = a - pcm_base;
        return (idx < 4) ? pcm_table[idx[1:0]] : PCM_END;
    endfunction

    assign rom_data = rom_byte(rom_addr);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        cen_cnt++;
        cen_opn = (cen_cnt % 4) == 0;
        cen_opl = (cen_cnt % 8) == 0;
    end

    // program rom and sample rom with random latency
    always @(posedge clk) begin
        #2;
        if (!rom_cs) begin
            rom_ok   = 1'b0;
            rom_wait = $urandom_range(4, 1);
        end else if (rom_wait == 0) rom_ok = 1'b1;
        else rom_wait--;
        if (!adpcm_cs) begin
            adpcm_ok = 1'b0;
            pcm_wait = $urandom_range(3, 0);
        end else if (!adpcm_ok) begin
            if (pcm_wait == 0) begin
                adpcm_ok   = 1'b1;
                adpcm_data = pcm_byte(adpcm_addr);
                fetched.push_back(adpcm_addr);
            end else pcm_wait--;
        end
    end

    task automatic check_value(input string name, input logic [17:0] got, input logic [17:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("error: %s", msg);
    endtask

    task automatic bus_write(input addr_t a, input data_t d);
        @(posedge clk);
        #1;
        cpu_addr = a;
        cpu_rnw  = 1'b0;
        cpu_dout = d;
        repeat (4) @(posedge clk);   // spans one cen_opn
        #1;
        cpu_rnw  = 1'b1;
        cpu_addr = IDLE;
    endtask

    task automatic bus_read(input addr_t a, output data_t d, output int waits);
        int n;
        @(posedge clk);
        #1;
        cpu_addr = a;
        cpu_rnw  = 1'b1;
        n = 0;
        waits = 0;
        #4;   // rdy as the cpu samples it at the next edge
        while (!rdy && n < 50) begin
            waits++;
            @(posedge clk);
            #5;
            if (rdy && rom_cs && !rom_ok) report_failure("rdy high before rom_ok");
            n++;
        end
        if (!rdy) report_failure("rdy stuck low on a read");
        @(posedge clk);   // ram and device reads are registered
        #5 d = cpu_din;
        @(posedge clk);
        #1;
        cpu_addr = IDLE;
    endtask

    task automatic ram_readback();
        addr_t a;
        data_t d, q;
        int w;
        repeat (8) begin
            a = addr_t'($urandom_range(2047, 0));
            d = data_t'($urandom);
            bus_write(a, d);
            bus_read(a, q, w);
            check_value("ram cpu_din", q, d);
        end
        bus_read(16'h1800, q, w);
        check_value("unmapped cpu_din", q, 8'hff);
    endtask

    task automatic rom_wait_states();
        data_t q;
        int w;
        bus_read(16'h9234, q, w);
        check_value("rom cpu_din", q, rom_byte(16'h9234));
        if (w == 0) report_failure("rdy never dropped during a rom read");
        bus_write(16'h8000, 8'h01);
        check_value("snd_bank", snd_bank, 1'b1);
        bus_write(16'h8000, 8'h00);
        check_value("snd_bank", snd_bank, 1'b0);
    endtask

    task automatic command_latch();
        data_t q;
        int w, n;
        latch = 8'hc3;
        @(posedge clk);
        #1 snreq = 1'b1;
        @(posedge clk);
        #1 snreq = 1'b0;
        n = 0;
        while (nmin && n < 20) begin
            @(posedge clk);
            #5 n++;
        end
        if (nmin) report_failure("nmin did not fall after snreq");
        bus_read(16'h3000, q, w);
        check_value("latch cpu_din", q, 8'hc3);
        check_value("nmin after latch read", nmin, 1'b1);
        // a held request fires once only
        @(posedge clk);
        #1 snreq = 1'b1;
        repeat (3) @(posedge clk);
        #5 check_value("nmin on held snreq", nmin, 1'b0);
        bus_read(16'h3000, q, w);
        repeat (20) @(posedge clk);
        #5 check_value("nmin with snreq held", nmin, 1'b1);
        snreq = 1'b0;
    endtask

    task automatic timer_interrupt();
        data_t q;
        int w, n;
        bus_write(16'h0802, 8'h03);    // reload
        bus_write(16'h0803, 8'h01);    // enable
        n = 0;
        while (irqn && n < 300) begin
            @(posedge clk);
            #5 n++;
        end
        if (irqn) report_failure("irqn did not fall for the opn timer");
        bus_read(16'h0800, q, w);
        check_value("opn status bit 7", q[7], 1'b1);
        bus_write(16'h0803, 8'h02);    // clear the flag and stop the timer
        @(posedge clk);
        #5 check_value("irqn after clear", irqn, 1'b1);
    endtask

    task automatic sample_playback();
        data_t q;
        int w, n;
        pcm_table = '{8'h10, 8'hf0, 8'h22, 8'h05};
        pcm_base  = {8'h12, 8'h34, 2'b00};
        fetched.delete();
        bus_write(16'h3800, 8'h12);
        bus_write(16'h3801, 8'h34);
        bus_read(16'h3800, q, w);
        check_value("pcm busy after start", q[0], 1'b1);
        n = 0;
        while (q[0] && n < 100) begin
            bus_read(16'h3800, q, w);
            n++;
        end
        if (q[0]) report_failure("pcm player stayed busy");
        check_value("pcm fetch count", 18'(fetched.size()), 18'd5);
        foreach (fetched[i]) check_value("adpcm_addr", fetched[i], pcm_base + adpcm_addr_t'(i));
    endtask

    task automatic measure_snd(input logic psg, input logic fm, output sample_t v);
        int k, t;
        @(posedge clk);
        #1;
        enable_psg = psg;
        enable_fm  = fm;
        k = 0;
        t = 0;
        while (k < 2 && t < 40) begin
            @(posedge clk);
            if (cen_opn) k++;
            t++;
        end
        if (k < 2) report_failure("no cen_opn tick while measuring snd");
        #5 v = snd;
    endtask

    task automatic mixer_sums();
        sample_t p, f, b, z, p2, f2;
        int n;
        fxlevel = 2'd2;
        bus_write(16'h0801, 8'h20);
        bus_write(16'h1001, 8'h11);
        bus_write(16'h0800, 8'hff);
        bus_write(16'h1000, 8'hff);
        // retry if a square edge falls inside the window
        for (n = 0; n < 4; n++) begin
            measure_snd(1'b1, 1'b0, p);
            measure_snd(1'b0, 1'b1, f);
            measure_snd(1'b1, 1'b1, b);
            measure_snd(1'b0, 1'b0, z);
            measure_snd(1'b1, 1'b0, p2);
            measure_snd(1'b0, 1'b1, f2);
            if (p == p2 && f == f2) break;
        end
        if (p != 16'sh0200 && p != -16'sh0200) check_value("snd psg only", p, 16'h0200);
        if (f != 16'sh0110 && f != -16'sh0110) check_value("snd fm only", f, 16'h0110);
        check_value("snd both", b, 16'(p + f));
        check_value("snd none", z, 16'h0000);
        check_value("peak small", peak, 1'b0);
        bus_write(16'h0801, 8'hff);
        bus_write(16'h0803, 8'h70);    // amp bits 10:8
        bus_write(16'h1001, 8'hff);
        bus_write(16'h1003, 8'h70);
        bus_write(16'h0800, 8'h03);
        bus_write(16'h1000, 8'h03);
        enable_psg = 1'b1;
        enable_fm  = 1'b1;
        n = 0;
        while (snd !== 16'h7fff && n < 2000) begin
            @(posedge clk);
            #5 n++;
        end
        if (snd !== 16'h7fff) report_failure("snd never saturated to 7fff");
        check_value("peak", peak, 1'b1);
    endtask

    initial begin
        seed = $urandom(32'hb8d776fa);
        rst = 1'b1;
        cen_opn = 1'b0;
        cen_opl = 1'b0;
        enable_psg = 1'b0;
        enable_fm = 1'b0;
        fxlevel = 2'd0;
        snreq = 1'b0;
        latch = 8'h00;
        cpu_addr = IDLE;
        cpu_rnw = 1'b1;
        cpu_dout = 8'h00;
        rom_ok = 1'b0;
        adpcm_ok = 1'b0;
        adpcm_data = 8'h00;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        ram_readback();
        rom_wait_states();
        command_latch();
        timer_interrupt();
        sample_playback();
        mixer_sums();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/snd_pkg.sv
source/snd_bus_if.sv
source/snd_decoder.sv
source/snd_ram.sv
source/snd_tone_chip.sv
source/snd_pcm_player.sv
source/snd_mixer.sv
source/snd_top.sv
tests/snd_properties.sv
tests/snd_tb.sv
